/* compile.f */
hdl/clock_pkg.sv
hdl/time_step_if.sv
hdl/tick_gen.sv
hdl/button_debounce.sv
hdl/mode_ctrl.sv
hdl/timekeeper.sv
hdl/alarm_timer.sv
hdl/seg_display.sv
hdl/hms_clock_top.sv
tests/tb_hms_clock.sv

/* hdl/alarm_timer.sv */
// ############################
// Alarm match detect and on-time counter
// ############################
module alarm_timer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_sec_tick,
    input  logic                        i_alarm_en,
    input  logic [clock_pkg::CNT_W-1:0] i_sec,
    input  logic [clock_pkg::CNT_W-1:0] i_min,
    input  logic [clock_pkg::CNT_W-1:0] i_al_sec,
    input  logic [clock_pkg::CNT_W-1:0] i_al_min,
    output logic                        o_alarm
);

    import clock_pkg::*;

    localparam int ACNT_W = $clog2(ALARM_SECS + 1);

    logic              match;
    logic [ACNT_W-1:0] on_secs;

    assign match = (i_sec == i_al_sec) && (i_min == i_al_min);

    // Seconds elapsed since the alarm went on, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            on_secs <= '0;
        end else if (!o_alarm) begin
            on_secs <= '0;
        end else if (i_sec_tick && (on_secs < ACNT_W'(ALARM_SECS))) begin
            on_secs <= on_secs + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_alarm <= 1'b0;
        end else if (!i_alarm_en) begin
            o_alarm <= 1'b0;
        end else if (match) begin
            o_alarm <= 1'b1;
        end else if (on_secs >= ACNT_W'(ALARM_SECS)) begin
            o_alarm <= 1'b0;
        end
    end

endmodule

/* hdl/button_debounce.sv */
// ############################
// Button sampler on the debounce tick,
// one press pulse per stable press
// ############################
module button_debounce (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_tick,
    input  logic [3:0] i_btn,
    output logic [3:0] o_press
);

    // Samples from the last two debounce ticks
    logic [3:0] samp_1;
    logic [3:0] samp_2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            samp_1 <= '0;
            samp_2 <= '0;
        end else if (i_tick) begin
            samp_1 <= i_btn;
            samp_2 <= samp_1;
        end
    end

    // High now and on the previous tick, low the tick before that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_press <= '0;
        end else if (i_tick) begin
            o_press <= i_btn & samp_1 & ~samp_2;
        end else begin
            o_press <= '0;
        end
    end

endmodule

/* hdl/clock_pkg.sv */
// ############################
// Shared types, widths and glyph table
// for the minutes-and-seconds clock
// ############################
package clock_pkg;

    typedef enum logic [1:0] {
        MODE_CLOCK = 2'd0,
        MODE_SETUP = 2'd1,
        MODE_ALARM = 2'd2
    } mode_t;

    typedef enum logic {
        POS_SEC = 1'b0,
        POS_MIN = 1'b1
    } pos_t;

    localparam int CNT_W      = 6;
    localparam int CNT_MAX    = 59;
    localparam int DIGIT_W    = 4;
    localparam int SEG_W      = 7;
    localparam int NUM_DIGITS = 4;
    localparam int ALARM_SECS = 10;

    // Segments a..g, a is the MSB, 1 lights the segment
    function automatic logic [SEG_W-1:0] seg_of_digit(input logic [DIGIT_W-1:0] digit);
        case (digit)
            4'd0:    return 7'b1111110;
            4'd1:    return 7'b0110000;
            4'd2:    return 7'b1101101;
            4'd3:    return 7'b1111001;
            4'd4:    return 7'b0110011;
            4'd5:    return 7'b1011011;
            4'd6:    return 7'b1011111;
            4'd7:    return 7'b1110000;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1110011;
            default: return 7'b0000000;
        endcase
    endfunction

endpackage

/* hdl/hms_clock_top.sv */
// ############################
// Clock top level, dividers set here
// and passed down to the tick generators
// ############################
module hms_clock_top #(
    parameter int SEC_DIV  = 50_000_000,
    parameter int SCAN_DIV = 50_000,
    parameter int DEB_DIV  = 500_000
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_btn_mode,
    input  logic                             i_btn_pos,
    input  logic                             i_btn_adj,
    input  logic                             i_btn_alarm,
    output logic [clock_pkg::SEG_W-1:0]      o_seg,
    output logic [clock_pkg::NUM_DIGITS-1:0] o_digit_en,
    output logic                             o_alarm
);

    import clock_pkg::*;

    logic             sec_tick;
    logic             scan_tick;
    logic             deb_tick;
    logic [3:0]       press;
    mode_t            mode;
    logic             alarm_en;
    logic [CNT_W-1:0] sec;
    logic [CNT_W-1:0] min;
    logic [CNT_W-1:0] al_sec;
    logic [CNT_W-1:0] al_min;

    time_step_if step_bus ();

    tick_gen #(.DIV(SEC_DIV))  u_sec_tick  (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
    tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
    tick_gen #(.DIV(DEB_DIV))  u_deb_tick  (.clk(clk), .rst_n(rst_n), .o_tick(deb_tick));

    button_debounce u_debounce (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_tick  (deb_tick),
        .i_btn   ({i_btn_alarm, i_btn_adj, i_btn_pos, i_btn_mode}),
        .o_press (press)
    );

    mode_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sec_tick (sec_tick),
        .i_press    (press),
        .o_mode     (mode),
        .o_alarm_en (alarm_en),
        .step       (step_bus)
    );

    timekeeper u_time (
        .clk      (clk),
        .rst_n    (rst_n),
        .step     (step_bus),
        .o_sec    (sec),
        .o_min    (min),
        .o_al_sec (al_sec),
        .o_al_min (al_min)
    );

    alarm_timer u_alarm (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sec_tick (sec_tick),
        .i_alarm_en (alarm_en),
        .i_sec      (sec),
        .i_min      (min),
        .i_al_sec   (al_sec),
        .i_al_min   (al_min),
        .o_alarm    (o_alarm)
    );

    seg_display u_disp (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_scan_tick (scan_tick),
        .i_mode      (mode),
        .i_sec       (sec),
        .i_min       (min),
        .i_al_sec    (al_sec),
        .i_al_min    (al_min),
        .o_seg       (o_seg),
        .o_digit_en  (o_digit_en)
    );

endmodule

/* hdl/mode_ctrl.sv */
// ############################
// Mode, position and alarm enable state,
// routes ticks and adjust presses to strobes
// ############################
module mode_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_sec_tick,
    input  logic [3:0]        i_press,
    output clock_pkg::mode_t  o_mode,
    output logic              o_alarm_en,
    time_step_if.ctrl         step
);

    import clock_pkg::*;

    // Press bit order
    localparam int BTN_MODE  = 0;
    localparam int BTN_POS   = 1;
    localparam int BTN_ADJ   = 2;
    localparam int BTN_ALARM = 3;

    mode_t mode;
    pos_t  pos;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode       <= MODE_CLOCK;
            pos        <= POS_SEC;
            o_alarm_en <= 1'b0;
        end else begin
            if (i_press[BTN_MODE]) begin
                case (mode)
                    MODE_CLOCK: mode <= MODE_SETUP;
                    MODE_SETUP: mode <= MODE_ALARM;
                    default:    mode <= MODE_CLOCK;
                endcase
            end
            if (i_press[BTN_POS]) begin
                pos <= (pos == POS_SEC) ? POS_MIN : POS_SEC;
            end
            if (i_press[BTN_ALARM]) begin
                o_alarm_en <= ~o_alarm_en;
            end
        end
    end

    assign o_mode = mode;

    always_comb begin
        // Clock stops only in setup
        step.run        = i_sec_tick && (mode != MODE_SETUP);
        step.sec_adj    = 1'b0;
        step.min_adj    = 1'b0;
        step.al_sec_adj = 1'b0;
        step.al_min_adj = 1'b0;
        if (i_press[BTN_ADJ]) begin
            case (mode)
                MODE_SETUP: begin
                    step.sec_adj = (pos == POS_SEC);
                    step.min_adj = (pos == POS_MIN);
                end
                MODE_ALARM: begin
                    step.al_sec_adj = (pos == POS_SEC);
                    step.al_min_adj = (pos == POS_MIN);
                end
                default: ;
            endcase
        end
    end

endmodule

/* hdl/seg_display.sv */
// ############################
// Four-digit multiplexed display of mm:ss,
// alarm time shown in alarm mode
// ############################
module seg_display (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_scan_tick,
    input  clock_pkg::mode_t                 i_mode,
    input  logic [clock_pkg::CNT_W-1:0]      i_sec,
    input  logic [clock_pkg::CNT_W-1:0]      i_min,
    input  logic [clock_pkg::CNT_W-1:0]      i_al_sec,
    input  logic [clock_pkg::CNT_W-1:0]      i_al_min,
    output logic [clock_pkg::SEG_W-1:0]      o_seg,
    output logic [clock_pkg::NUM_DIGITS-1:0] o_digit_en
);

    import clock_pkg::*;

    localparam int SCAN_W = $clog2(NUM_DIGITS);

    logic [CNT_W-1:0]   show_sec;
    logic [CNT_W-1:0]   show_min;
    logic [DIGIT_W-1:0] digits [NUM_DIGITS];
    logic [SCAN_W-1:0]  scan;

    assign show_sec = (i_mode == MODE_ALARM) ? i_al_sec : i_sec;
    assign show_min = (i_mode == MODE_ALARM) ? i_al_min : i_min;

    // Units first, minutes tens last
    assign digits[0] = DIGIT_W'(show_sec % 10);
    assign digits[1] = DIGIT_W'(show_sec / 10);
    assign digits[2] = DIGIT_W'(show_min % 10);
    assign digits[3] = DIGIT_W'(show_min / 10);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan <= '0;
        end else if (i_scan_tick) begin
            if (scan == SCAN_W'(NUM_DIGITS - 1)) begin
                scan <= '0;
            end else begin
                scan <= scan + 1'b1;
            end
        end
    end

    // Active low digit enable
    assign o_digit_en = ~(NUM_DIGITS'(1) << scan);
    assign o_seg      = seg_of_digit(digits[scan]);

endmodule

/* hdl/tick_gen.sv */
// ############################
// Clock divider, one-cycle enable every DIV clocks
// ############################
module tick_gen #(
    parameter int DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic o_tick
);

    localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == CW'(DIV - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // High in the last count of each period
    assign o_tick = (cnt == CW'(DIV - 1));

endmodule

/* hdl/time_step_if.sv */
// ############################
// Step strobes from the mode controller
// to the timekeeper counters
// ############################
interface time_step_if;

    logic run;
    logic sec_adj;
    logic min_adj;
    logic al_sec_adj;
    logic al_min_adj;

    modport ctrl (
        output run, sec_adj, min_adj, al_sec_adj, al_min_adj
    );

    modport count (
        input run, sec_adj, min_adj, al_sec_adj, al_min_adj
    );

endinterface

/* hdl/timekeeper.sv */
// ############################
// Running time and alarm time counters,
// stepped by the controller strobes
// ############################
module timekeeper (
    input  logic                        clk,
    input  logic                        rst_n,
    time_step_if.count                  step,
    output logic [clock_pkg::CNT_W-1:0] o_sec,
    output logic [clock_pkg::CNT_W-1:0] o_min,
    output logic [clock_pkg::CNT_W-1:0] o_al_sec,
    output logic [clock_pkg::CNT_W-1:0] o_al_min
);

    import clock_pkg::*;

    function automatic logic [CNT_W-1:0] inc_wrap(input logic [CNT_W-1:0] val);
        return (val == CNT_W'(CNT_MAX)) ? '0 : val + 1'b1;
    endfunction

    // Running time, carry only on the second tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_sec <= '0;
            o_min <= '0;
        end else if (step.run) begin
            o_sec <= inc_wrap(o_sec);
            if (o_sec == CNT_W'(CNT_MAX)) begin
                o_min <= inc_wrap(o_min);
            end
        end else begin
            if (step.sec_adj) begin
                o_sec <= inc_wrap(o_sec);
            end
            if (step.min_adj) begin
                o_min <= inc_wrap(o_min);
            end
        end
    end

    // Alarm time, set by hand only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_al_sec <= '0;
            o_al_min <= '0;
        end else begin
            if (step.al_sec_adj) begin
                o_al_sec <= inc_wrap(o_al_sec);
            end
            if (step.al_min_adj) begin
                o_al_min <= inc_wrap(o_al_min);
            end
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hms_clock -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_hms_clock)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tests/tb_hms_clock.sv */
// ############################
// Testbench for the clock top level, applies a step table
// and checks the display and o_alarm against a reference model
// ############################
module tb_hms_clock;

    localparam int SEC_DIV    = 200;
    localparam int SCAN_DIV   = 4;
    localparam int DEB_DIV    = 8;
    localparam int ALARM_SECS = 10;

    localparam int ACT_WAIT      = 0;
    localparam int ACT_PRESS     = 1;
    localparam int ACT_ALARM_ON  = 2;
    localparam int ACT_ALARM_OFF = 3;
    localparam int BTN_MODE      = 0;
    localparam int BTN_POS       = 1;
    localparam int BTN_ADJ       = 2;
    localparam int BTN_ALARM     = 3;
    localparam int SHOW_TIME     = 0;
    localparam int SHOW_ALARM    = 1;
    // Press counts below zero are resolved at run time
    localparam int CNT_RAND      = -1;
    localparam int CNT_AHEAD     = -2;
    localparam int M_SETUP       = 1;
    localparam int M_ALARM       = 2;
    localparam int N_STEPS       = 21;

    typedef struct {
        int act;
        int btn;
        int count;
        int show;
        int exp_alarm;
    } step_t;

    step_t steps [N_STEPS] = '{
        '{ACT_WAIT,      BTN_MODE,  0,         SHOW_TIME,  0},
        '{ACT_WAIT,      BTN_MODE,  65,        SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_MODE,  1,         SHOW_TIME,  0},
        '{ACT_WAIT,      BTN_MODE,  3,         SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_ADJ,   CNT_RAND,  SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_POS,   1,         SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_ADJ,   CNT_RAND,  SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_MODE,  1,         SHOW_ALARM, 0},
        '{ACT_PRESS,     BTN_POS,   1,         SHOW_ALARM, 0},
        '{ACT_PRESS,     BTN_ADJ,   CNT_RAND,  SHOW_ALARM, 0},
        '{ACT_PRESS,     BTN_POS,   1,         SHOW_ALARM, 0},
        '{ACT_PRESS,     BTN_ADJ,   CNT_AHEAD, SHOW_ALARM, 0},
        '{ACT_PRESS,     BTN_MODE,  1,         SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_ALARM, 1,         SHOW_TIME,  0},
        '{ACT_ALARM_ON,  BTN_MODE,  0,         SHOW_TIME,  1},
        '{ACT_ALARM_OFF, BTN_MODE,  0,         SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_ALARM, 1,         SHOW_TIME,  0},
        '{ACT_PRESS,     BTN_MODE,  2,         SHOW_ALARM, 0},
        '{ACT_PRESS,     BTN_ADJ,   CNT_AHEAD, SHOW_ALARM, 0},
        '{ACT_PRESS,     BTN_MODE,  1,         SHOW_TIME,  0},
        '{ACT_WAIT,      BTN_MODE,  180,       SHOW_TIME,  0}
    };

    logic       clk;
    logic       rst_n;
    logic       btn_mode;
    logic       btn_pos;
    logic       btn_adj;
    logic       btn_alarm;
    logic [6:0] seg;
    logic [3:0] digit_en;
    logic       alarm;

    // Reference model state
    int          edge_cnt   = 0;
    int          run_secs   = 0;
    int          seen_secs  = 0;
    int          model_mode = 0;
    int          model_pos  = 0;
    int          model_sec  = 0;
    int          model_min  = 0;
    int          al_sec     = 0;
    int          al_min     = 0;
    int          rise_cnt   = 0;
    logic [31:0] rng_state  = 32'h98c0_fa09;

    hms_clock_top #(
        .SEC_DIV  (SEC_DIV),
        .SCAN_DIV (SCAN_DIV),
        .DEB_DIV  (DEB_DIV)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_btn_mode  (btn_mode),
        .i_btn_pos   (btn_pos),
        .i_btn_adj   (btn_adj),
        .i_btn_alarm (btn_alarm),
        .o_seg       (seg),
        .o_digit_en  (digit_en),
        .o_alarm     (alarm)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Second tick lands on every SEC_DIV-th edge after reset
    always @(posedge clk) begin
        if (rst_n) begin
            edge_cnt <= edge_cnt + 1;
            if ((edge_cnt + 1) % SEC_DIV == 0 && model_mode != M_SETUP) begin
                run_secs <= run_secs + 1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int segments_to_digit(input logic [6:0] s);
        case (s)
            7'b1111110: return 0;
            7'b0110000: return 1;
            7'b1101101: return 2;
            7'b1111001: return 3;
            7'b0110011: return 4;
            7'b1011011: return 5;
            7'b1011111: return 6;
            7'b1110000: return 7;
            7'b1111111: return 8;
            7'b1110011: return 9;
            default:    return -1;
        endcase
    endfunction

    // Running time catches up with the elapsed seconds and carries into the minutes
    function automatic void sync_model();
        while (seen_secs < run_secs) begin
            seen_secs++;
            model_sec = (model_sec + 1) % 60;
            if (model_sec == 0) begin
                model_min = (model_min + 1) % 60;
            end
        end
    endfunction

    function automatic int resolve_count(input int code);
        if (code == CNT_RAND) begin
            rng_state = xorshift32(rng_state);
            return 60 + int'(rng_state % 60);
        end
        if (code == CNT_AHEAD) begin
            sync_model();
            return ((model_min + 2) % 60 - al_min + 60) % 60;
        end
        return code;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_phase(input int phase);
        int n;
        n = 0;
        next_edge();
        while (edge_cnt % SEC_DIV != phase && n < 2 * SEC_DIV) begin
            next_edge();
            n++;
        end
        assert (edge_cnt % SEC_DIV == phase) else begin
            report_failure("timed out waiting for a point within the second");
            $fatal(1);
        end
    endtask

    task automatic wait_alarm(input logic level, input int limit);
        int n;
        n = 0;
        while (alarm !== level && n < limit) begin
            next_edge();
            n++;
        end
        assert (alarm === level) else begin
            report_failure($sformatf("timed out waiting for o_alarm to become %0b", level));
            $fatal(1);
        end
    endtask

    task automatic drive_button(input int btn, input logic level);
        case (btn)
            BTN_MODE:  btn_mode = level;
            BTN_POS:   btn_pos = level;
            BTN_ADJ:   btn_adj = level;
            BTN_ALARM: btn_alarm = level;
            default: ;
        endcase
    endtask

    task automatic press_button(input int btn);
        // Mode changes kept clear of the second tick
        if (btn == BTN_MODE) begin
            wait_phase(10);
        end
        drive_button(btn, 1'b1);
        repeat (4 * DEB_DIV) next_edge();
        drive_button(btn, 1'b0);
        repeat (4 * DEB_DIV) next_edge();
        sync_model();
        if (btn == BTN_MODE) begin
            model_mode = (model_mode + 1) % 3;
        end else if (btn == BTN_POS) begin
            model_pos = 1 - model_pos;
        end else if (btn == BTN_ADJ && model_mode == M_SETUP) begin
            if (model_pos == 0) model_sec = (model_sec + 1) % 60;
            else model_min = (model_min + 1) % 60;
        end else if (btn == BTN_ADJ && model_mode == M_ALARM) begin
            if (model_pos == 0) al_sec = (al_sec + 1) % 60;
            else al_min = (al_min + 1) % 60;
        end
    endtask

    task automatic hold_seconds(input int secs, input int exp_alarm);
        repeat (secs * SEC_DIV) begin
            next_edge();
            assert (alarm === exp_alarm[0]) else begin
                report_failure($sformatf("error at %0t: o_alarm is %0b, expected %0b",
                                         $time, alarm, exp_alarm[0]));
                $fatal(1);
            end
        end
    endtask

    task automatic read_display(output int mm, output int ss);
        int dig [4];
        int n;
        for (int d = 0; d < 4; d++) begin
            n = 0;
            while (digit_en !== ~(4'b0001 << d) && n < 8 * SCAN_DIV) begin
                next_edge();
                n++;
            end
            assert (digit_en === ~(4'b0001 << d)) else begin
                report_failure($sformatf("display digit %0d was never enabled", d));
                $fatal(1);
            end
            dig[d] = segments_to_digit(seg);
            assert (dig[d] >= 0) else begin
                report_failure($sformatf("display digit %0d shows no decimal glyph", d));
                $fatal(1);
            end
        end
        ss = dig[1] * 10 + dig[0];
        mm = dig[3] * 10 + dig[2];
    endtask

    task automatic check_step(input step_t s);
        int mm;
        int ss;
        int exp_mm;
        int exp_ss;
        wait_phase(SEC_DIV / 2);
        sync_model();
        read_display(mm, ss);
        exp_mm = (s.show == SHOW_ALARM) ? al_min : model_min;
        exp_ss = (s.show == SHOW_ALARM) ? al_sec : model_sec;
        assert (mm == exp_mm && ss == exp_ss) else begin
            report_failure($sformatf("error at %0t: o_seg shows %02d:%02d, expected %02d:%02d",
                                     $time, mm, ss, exp_mm, exp_ss));
            $fatal(1);
        end
        assert (alarm === s.exp_alarm[0]) else begin
            report_failure($sformatf("error at %0t: o_alarm is %0b, expected %0b",
                                     $time, alarm, s.exp_alarm[0]));
            $fatal(1);
        end
    endtask

    initial begin
        int count;
        rst_n     = 1'b0;
        btn_mode  = 1'b0;
        btn_pos   = 1'b0;
        btn_adj   = 1'b0;
        btn_alarm = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < N_STEPS; i++) begin
            count = resolve_count(steps[i].count);
            case (steps[i].act)
                ACT_WAIT: hold_seconds(count, steps[i].exp_alarm);
                ACT_PRESS: repeat (count) press_button(steps[i].btn);
                ACT_ALARM_ON: begin
                    wait_alarm(1'b1, 200 * SEC_DIV);
                    rise_cnt = edge_cnt;
                    sync_model();
                    assert (model_min == al_min && model_sec == al_sec) else begin
                        report_failure("o_alarm rose while the time differs from the alarm");
                        $fatal(1);
                    end
                end
                ACT_ALARM_OFF: begin
                    wait_alarm(1'b0, (ALARM_SECS + 1) * SEC_DIV - (edge_cnt - rise_cnt));
                    assert (edge_cnt - rise_cnt >= (ALARM_SECS - 1) * SEC_DIV) else begin
                        report_failure("o_alarm fell before the alarm time ran out");
                        $fatal(1);
                    end
                end
                default: ;
            endcase
            check_step(steps[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
